// File: verilog/execTypesPkg.sv
package execTypesPkg;

	localparam int WORD_WIDTH = 32;
	localparam int SHIFT_WIDTH = $clog2(WORD_WIDTH);
	localparam int MULT_STEPS = 32;
	localparam int STEP_WIDTH = $clog2(MULT_STEPS) + 1;
	localparam int LHI_SHIFT = 16;

	typedef logic [WORD_WIDTH-1:0] wordT;
	typedef logic [STEP_WIDTH-1:0] stepCountT;

	// reference ALU ordering, multiply appended last
	typedef enum logic [3:0] {
		opSll = 4'd0,
		opSrl = 4'd1,
		opSra = 4'd2,
		opAdd = 4'd3,
		opSub = 4'd4,
		opOr = 4'd5,
		opAnd = 4'd6,
		opXor = 4'd7,
		opSeq = 4'd8,
		opSne = 4'd9,
		opSlt = 4'd10,
		opSgt = 4'd11,
		opSle = 4'd12,
		opSge = 4'd13,
		opLhi = 4'd14,
		opMult = 4'd15
	} execOpE;

	typedef struct packed {
		execOpE op;
		wordT operandA;
		wordT operandB;
	} execCmdT;

	typedef struct packed {
		wordT value;
		logic branchTaken;
	} execResultT;

endpackage

// File: verilog/creditPkg.sv
package creditPkg;

	// queue depth equals the sender's starting credits
	localparam int CMD_CREDITS = 4;
	localparam int CMD_PTR_WIDTH = $clog2(CMD_CREDITS);

	// grant the consumer hands out after reset
	localparam int RESULT_CREDITS = 2;

	typedef logic [2:0] creditCountT;
	typedef logic [CMD_PTR_WIDTH-1:0] cmdPtrT;

endpackage

// File: verilog/commandQueue.sv
`timescale 1ns/1ns

module commandQueue import execTypesPkg::*, creditPkg::*; (
	input  logic    clock,
	input  logic    arstN,
	input  logic    cmdValid,
	input  execCmdT cmd,
	input  logic    pop,
	output logic    headValid,
	output execCmdT head,
	output logic    cmdCredit
);

	execCmdT entries [CMD_CREDITS];
	cmdPtrT wrPtr;
	cmdPtrT rdPtr;
	creditCountT fillCount;

	always_ff @(posedge clock) begin
		if (cmdValid)
			entries[wrPtr] <= cmd;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
			cmdCredit <= 1'b0;
		end else begin
			if (cmdValid)
				wrPtr <= wrPtr + cmdPtrT'(1);
			if (pop)
				rdPtr <= rdPtr + cmdPtrT'(1);
			case ({cmdValid, pop})
				2'b10: fillCount <= fillCount + creditCountT'(1);
				2'b01: fillCount <= fillCount - creditCountT'(1);
				default: fillCount <= fillCount;
			endcase
			cmdCredit <= pop; // credit goes back a cycle after the pop
		end
	end

	assign headValid = fillCount != '0;
	assign head = entries[rdPtr];

	// sender pushed without holding a credit
	assert property (@(posedge clock) disable iff (!arstN)
		cmdValid |-> fillCount != creditCountT'(CMD_CREDITS))
		else $error("command queue written while full");

	// execute stage must only pop a present head
	assert property (@(posedge clock) disable iff (!arstN)
		pop |-> headValid)
		else $error("pop from empty command queue");

endmodule

// File: verilog/integerAlu.sv
`timescale 1ns/1ns

module integerAlu import execTypesPkg::*; (
	input  execOpE op,
	input  wordT   operandA,
	input  wordT   operandB,
	output wordT   value
);

	logic isEqual;
	logic isLess;
	logic bigShift;
	logic [SHIFT_WIDTH-1:0] shiftAmount;

	assign isEqual = operandA == operandB;
	assign isLess = operandA < operandB; // unsigned

	// whole of B counts as the shift amount
	assign bigShift = operandB >= wordT'(WORD_WIDTH);
	assign shiftAmount = operandB[SHIFT_WIDTH-1:0];

	always_comb begin
		case (op)
			opSll: value = bigShift ? '0 : operandA << shiftAmount;
			opSrl: value = bigShift ? '0 : operandA >> shiftAmount;
			opSra: begin
				if (bigShift)
					value = {WORD_WIDTH{operandA[WORD_WIDTH-1]}};
				else
					value = wordT'($signed(operandA) >>> shiftAmount);
			end
			opAdd: value = operandA + operandB;
			opSub: value = operandA - operandB;
			opOr: value = operandA | operandB;
			opAnd: value = operandA & operandB;
			opXor: value = operandA ^ operandB;
			opSeq: value = wordT'(isEqual);
			opSne: value = wordT'(!isEqual);
			opSlt: value = wordT'(isLess);
			opSgt: value = wordT'(!isLess && !isEqual);
			opSle: value = wordT'(isLess || isEqual);
			opSge: value = wordT'(!isLess);
			opLhi: value = operandB << LHI_SHIFT; // low half of B moves up
			default: value = '0; // multiply handled elsewhere
		endcase
	end

endmodule

// File: verilog/shiftAddMultiplier.sv
`timescale 1ns/1ns

module shiftAddMultiplier import execTypesPkg::*; (
	input  logic clock,
	input  logic arstN,
	input  logic multStart,
	input  wordT multiplicand,
	input  wordT multiplier,
	output logic multDone,
	output wordT product
);

	stepCountT stepCount;
	wordT shiftedCand;
	wordT multBits;
	wordT accumulator;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			stepCount <= '0;
			multDone <= 1'b0;
		end else begin
			multDone <= 1'b0;
			if (multStart)
				stepCount <= stepCountT'(MULT_STEPS);
			else if (stepCount != '0) begin
				stepCount <= stepCount - stepCountT'(1);
				if (stepCount == stepCountT'(1))
					multDone <= 1'b1; // last partial product lands now
			end
		end
	end

	// one partial product per clock, lsb of the multiplier first
	always_ff @(posedge clock) begin
		if (multStart) begin
			shiftedCand <= multiplicand;
			multBits <= multiplier;
			accumulator <= '0;
		end else if (stepCount != '0) begin
			if (multBits[0])
				accumulator <= accumulator + shiftedCand;
			shiftedCand <= shiftedCand << 1;
			multBits <= multBits >> 1;
		end
	end

	assign product = accumulator; // upper product bits never kept

	assert property (@(posedge clock) disable iff (!arstN)
		multStart |-> stepCount == '0)
		else $error("multiply started while one is running");

	// start edge, then the steps, then the edge that samples multDone
	assert property (@(posedge clock) disable iff (!arstN)
		multDone |-> $past(multStart, MULT_STEPS + 1))
		else $error("multiply finished after the wrong number of steps");

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/1ns

module executeStage import execTypesPkg::*; (
	input  logic       clock,
	input  logic       arstN,
	input  logic       headValid,
	input  execCmdT    head,
	output logic       pop,
	output logic       doneValid,
	output execResultT done,
	input  logic       doneTaken
);

	typedef enum logic [1:0] {
		stIdle,
		stMultiplying,
		stHolding
	} execStateE;

	execStateE state;
	wordT aluValue;
	wordT product;
	logic multStart;
	logic multDone;

	integerAlu u_integerAlu (
		.op(head.op),
		.operandA(head.operandA),
		.operandB(head.operandB),
		.value(aluValue)
	);

	shiftAddMultiplier u_shiftAddMultiplier (
		.clock(clock),
		.arstN(arstN),
		.multStart(multStart),
		.multiplicand(head.operandA),
		.multiplier(head.operandB),
		.multDone(multDone),
		.product(product)
	);

	// idle means nothing is held, so a head can be taken
	assign pop = state == stIdle && headValid;
	assign multStart = pop && head.op == opMult;
	assign doneValid = state == stHolding;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			state <= stIdle;
		else begin
			case (state)
				stIdle: if (pop) state <= multStart ? stMultiplying : stHolding;
				stMultiplying: if (multDone) state <= stHolding;
				default: if (doneTaken) state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (pop && !multStart) begin
			done.value <= aluValue;
			done.branchTaken <= aluValue[0]; // branch flag from result lsb
		end else if (state == stMultiplying && multDone) begin
			done.value <= product;
			done.branchTaken <= 1'b0;
		end
	end

endmodule

// File: verilog/resultIssue.sv
`timescale 1ns/1ns

module resultIssue import execTypesPkg::*, creditPkg::*; (
	input  logic       clock,
	input  logic       arstN,
	input  logic       doneValid,
	input  execResultT done,
	output logic       doneTaken,
	input  logic       resultCredit,
	output logic       resultValid,
	output execResultT result
);

	creditCountT creditCount;

	// issue only while the consumer has room
	assign resultValid = doneValid && creditCount != '0;
	assign doneTaken = resultValid;
	assign result = done;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			creditCount <= creditCountT'(RESULT_CREDITS);
		else begin
			case ({resultValid, resultCredit})
				2'b10: creditCount <= creditCount - creditCountT'(1);
				2'b01: creditCount <= creditCount + creditCountT'(1);
				default: creditCount <= creditCount; // spend and return cancel
			endcase
		end
	end

	// consumer returned more than it was granted
	assert property (@(posedge clock) disable iff (!arstN)
		resultCredit |=> creditCount <= creditCountT'(RESULT_CREDITS))
		else $error("result credit count above grant");

endmodule

// File: verilog/dlxExecUnit.sv
`timescale 1ns/1ns

module dlxExecUnit import execTypesPkg::*; (
	input  logic       clock,
	input  logic       arstN,
	input  logic       cmdValid,
	input  execCmdT    cmd,
	output logic       cmdCredit,
	output logic       resultValid,
	output execResultT result,
	input  logic       resultCredit
);

	logic headValid;
	execCmdT head;
	logic pop;
	logic doneValid;
	execResultT done;
	logic doneTaken;

	commandQueue u_commandQueue (
		.clock(clock),
		.arstN(arstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.pop(pop),
		.headValid(headValid),
		.head(head),
		.cmdCredit(cmdCredit)
	);

	executeStage u_executeStage (
		.clock(clock),
		.arstN(arstN),
		.headValid(headValid),
		.head(head),
		.pop(pop),
		.doneValid(doneValid),
		.done(done),
		.doneTaken(doneTaken)
	);

	resultIssue u_resultIssue (
		.clock(clock),
		.arstN(arstN),
		.doneValid(doneValid),
		.done(done),
		.doneTaken(doneTaken),
		.resultCredit(resultCredit),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

// File: include/dlxExecModel.svh
`ifndef DLX_EXEC_MODEL_SVH
`define DLX_EXEC_MODEL_SVH

// 32-bit linear congruential step
function automatic wordT lcgNext(input wordT state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic execResultT modelExec(input execCmdT c);
	execResultT r;
	wordT a;
	wordT b;
	a = c.operandA;
	b = c.operandB;
	case (c.op)
		opSll: r.value = (b >= 32) ? '0 : a << b[4:0];
		opSrl: r.value = (b >= 32) ? '0 : a >> b[4:0];
		opSra: r.value = (b >= 32) ? {32{a[31]}} : wordT'($signed(a) >>> b[4:0]);
		opAdd: r.value = a + b;
		opSub: r.value = a - b;
		opOr: r.value = a | b;
		opAnd: r.value = a & b;
		opXor: r.value = a ^ b;
		opSeq: r.value = wordT'(a == b);
		opSne: r.value = wordT'(a != b);
		opSlt: r.value = wordT'(a < b);
		opSgt: r.value = wordT'(a > b);
		opSle: r.value = wordT'(a <= b);
		opSge: r.value = wordT'(a >= b);
		opLhi: r.value = {b[15:0], 16'h0000};
		default: r.value = a * b; // low half of the product
	endcase
	r.branchTaken = (c.op == opMult) ? 1'b0 : r.value[0];
	return r;
endfunction

task automatic checkResult(input string name, input execResultT actual,
		input execResultT expected);
	if (actual !== expected) begin
		$display("MISMATCH at %0t: %s got value %h branch %b, expected value %h branch %b",
			$time, name, actual.value, actual.branchTaken,
			expected.value, expected.branchTaken);
		$display("SIMULATION FAILED");
		$fatal(1, "result mismatch on %s", name);
	end
endtask

task automatic checkCredits(input string name, input int actual, input int expected);
	if (actual != expected) begin
		$display("MISMATCH at %0t: %s got %0d, expected %0d", $time, name, actual, expected);
		$display("SIMULATION FAILED");
		$fatal(1, "credit mismatch on %s", name);
	end
endtask

`endif

// File: bench/dlxExecTb.sv
`timescale 1ns/1ns

module dlxExecTb import execTypesPkg::*, creditPkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam wordT SEED = 32'd50490;

	logic clock;
	logic arstN;
	logic cmdValid;
	execCmdT cmd;
	logic cmdCredit;
	logic resultValid;
	execResultT result;
	logic resultCredit;

	execResultT expQ[$]; // results still owed by the DUT, oldest first
	wordT lcgState;
	int cmdCreditsHeld;
	int pendingReturns;
	int creditPulses;
	int resultsSeen;
	int issuedCount;
	int cycleCount;
	logic returnEnable;

	`include "dlxExecModel.svh"

	dlxExecUnit u_dlxExecUnit (
		.clock(clock),
		.arstN(arstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.cmdCredit(cmdCredit),
		.resultValid(resultValid),
		.result(result),
		.resultCredit(resultCredit)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic wordT nextRandom();
		lcgState = lcgNext(lcgState);
		return lcgState;
	endfunction

	function automatic execCmdT makeCmd(input execOpE op, input wordT a, input wordT b);
		execCmdT c;
		c.op = op;
		c.operandA = a;
		c.operandB = b;
		return c;
	endfunction

	task automatic failRun(input string what);
		$display("%0t: %s", $time, what);
		$display("SIMULATION FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s got %b, expected %b", $time, name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "flag mismatch on %s", name);
		end
	endtask

	// sender side: credits come back on cmdCredit, results checked in order
	initial begin
		forever begin
			@(posedge clock);
			if (arstN && cmdCredit) begin
				cmdCreditsHeld++;
				creditPulses++;
			end
			if (arstN && resultValid) begin
				if (expQ.size() == 0)
					failRun("result issued with no command outstanding");
				else
					checkResult("result", result, expQ.pop_front());
				resultsSeen++;
				pendingReturns++;
			end
		end
	end

	// consumer hands back one credit per cycle
	initial begin
		forever begin
			@(negedge clock);
			if (arstN && returnEnable && pendingReturns > 0) begin
				resultCredit = 1'b1;
				pendingReturns--;
			end else
				resultCredit = 1'b0;
		end
	end

	initial begin
		cycleCount = 0;
		while (cycleCount <= 40 * issuedCount + 200) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("watchdog expired after %0d cycles with %0d commands issued",
			cycleCount, issuedCount);
		$display("SIMULATION FAILED");
		$fatal(1, "simulation hung");
	end

	task automatic resetDut();
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmdCreditsHeld = CMD_CREDITS;
		pendingReturns = 0;
		creditPulses = 0;
		repeat (RESET_CYCLES) @(negedge clock);
		arstN = 1'b1;
	endtask

	task automatic sendCmd(input execCmdT c);
		while (cmdCreditsHeld == 0)
			@(negedge clock);
		cmdValid = 1'b1;
		cmd = c;
		cmdCreditsHeld--;
		issuedCount++;
		expQ.push_back(modelExec(c));
		@(negedge clock);
		cmdValid = 1'b0;
	endtask

	task automatic waitResults();
		int waited;
		int limit;
		waited = 0;
		limit = 40 * expQ.size() + 50;
		while (expQ.size() != 0 && waited < limit) begin
			@(negedge clock);
			waited++;
		end
		if (expQ.size() != 0)
			failRun("timed out waiting for outstanding results");
		else begin
			repeat (4) @(negedge clock); // let the last credits travel back
			checkCredits("command credits held", cmdCreditsHeld, CMD_CREDITS);
		end
	endtask

	task automatic testResetState();
		resetDut();
		repeat (20) begin
			@(posedge clock);
			checkFlag("resultValid", resultValid, 1'b0);
			checkFlag("cmdCredit", cmdCredit, 1'b0);
		end
		@(negedge clock);
		sendCmd(makeCmd(opAdd, 32'd5, 32'd6));
		waitResults();
	endtask

	task automatic testAluOps();
		wordT a;
		wordT b;
		execOpE op;
		for (int i = 0; i < 15; i++) begin
			op = execOpE'(i[3:0]);
			a = nextRandom();
			b = nextRandom();
			sendCmd(makeCmd(op, 32'h8000_00f1, 32'd0));
			sendCmd(makeCmd(op, 32'h8000_00f1, 32'd31));
			sendCmd(makeCmd(op, 32'h8000_00f1, 32'd40)); // past the word width
			sendCmd(makeCmd(op, a, a));
			sendCmd(makeCmd(op, a, a + 32'd1));
			sendCmd(makeCmd(op, a + 32'd1, a));
			sendCmd(makeCmd(op, a, b));
			sendCmd(makeCmd(op, b, 32'h1234_abcd)); // lhi keeps only abcd
		end
		waitResults();
	endtask

	task automatic testBranchFlag();
		sendCmd(makeCmd(opSeq, 32'd7, 32'd7));
		sendCmd(makeCmd(opSne, 32'd7, 32'd7));
		sendCmd(makeCmd(opSlt, 32'd3, 32'd9));
		sendCmd(makeCmd(opSgt, 32'd3, 32'd9));
		sendCmd(makeCmd(opSge, 32'd9, 32'd3));
		sendCmd(makeCmd(opAdd, 32'd4, 32'd5)); // odd sum
		sendCmd(makeCmd(opAdd, 32'd4, 32'd6));
		sendCmd(makeCmd(opMult, 32'd3, 32'd5)); // odd product, flag stays low
		waitResults();
	endtask

	task automatic testMultiply();
		sendCmd(makeCmd(opMult, 32'd0, 32'hdead_beef));
		sendCmd(makeCmd(opMult, 32'd1, 32'hdead_beef));
		sendCmd(makeCmd(opMult, 32'hdead_beef, 32'd1));
		sendCmd(makeCmd(opMult, 32'hffff_ffff, 32'hffff_ffff));
		sendCmd(makeCmd(opMult, 32'hffff_ffff, 32'd2));
		repeat (6)
			sendCmd(makeCmd(opMult, nextRandom(), nextRandom()));
		waitResults();
	endtask

	task automatic testCreditsOrdering();
		resetDut();
		sendCmd(makeCmd(opMult, 32'h0001_0003, 32'h0000_0101));
		sendCmd(makeCmd(opAdd, 32'd100, 32'd23));
		// first pop only happens now, so no credit can be back yet
		checkCredits("cmdCredit pulses before first pop", creditPulses, 0);
		sendCmd(makeCmd(opMult, 32'd12345, 32'd678));
		sendCmd(makeCmd(opSub, 32'd10, 32'd20));
		waitResults();
	endtask

	task automatic testBackPressure();
		int seenBefore;
		int pulsesBefore;
		int pulsesFull;
		returnEnable = 1'b0;
		@(negedge clock);
		seenBefore = resultsSeen;
		pulsesBefore = creditPulses;
		// granted results + one held + a full queue
		repeat (RESULT_CREDITS + 1 + CMD_CREDITS)
			sendCmd(makeCmd(opXor, nextRandom(), nextRandom()));
		repeat (30) @(negedge clock);
		checkCredits("results without credit return", resultsSeen - seenBefore,
			RESULT_CREDITS);
		checkCredits("cmdCredit pulses until full", creditPulses - pulsesBefore,
			RESULT_CREDITS + 1);
		checkCredits("command credits while blocked", cmdCreditsHeld, 0);
		pulsesFull = creditPulses;
		repeat (20) @(negedge clock);
		checkCredits("cmdCredit pulses after full", creditPulses - pulsesFull, 0);
		returnEnable = 1'b1;
		waitResults();
	endtask

	initial begin
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmd = '0;
		resultCredit = 1'b0;
		returnEnable = 1'b1;
		lcgState = SEED;
		cmdCreditsHeld = CMD_CREDITS;
		pendingReturns = 0;
		creditPulses = 0;
		resultsSeen = 0;
		issuedCount = 0;
		testResetState();
		testAluOps();
		testBranchFlag();
		testMultiply();
		testCreditsOrdering();
		testBackPressure();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: dlxExecUnit.f
+incdir+include
verilog/execTypesPkg.sv
verilog/creditPkg.sv
verilog/commandQueue.sv
verilog/integerAlu.sv
verilog/shiftAddMultiplier.sv
verilog/executeStage.sv
verilog/resultIssue.sv
verilog/dlxExecUnit.sv
bench/dlxExecTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -f dlxExecUnit.f \
	--top-module dlxExecTb -o dlxExecSim || exit 1
simOut="$(./obj_dir/dlxExecSim 2>&1)"
echo "$simOut"
echo "$simOut" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
